// File: design/rrag_pkg.sv
package rrag_pkg;

    // widths are fixed by the architecture
    localparam int ADDR_W   = 32;
    localparam int EIP_W    = 32;
    localparam int OPSIZE_W = 2;
    localparam int SCALE_W  = 2;
    localparam int MEM_RW_W = 2;
    localparam int EXC_W    = 4;

    // linear and logical addresses, segment base and limit
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [EIP_W-1:0]    eip_t;

    // 0..3 selects 1, 2, 4 or 8 bytes
    typedef logic [OPSIZE_W-1:0] opsize_t;

    typedef logic [SCALE_W-1:0]  scale_t;   // left shift applied to the index

    // bit 0 is a read and bit 1 a write, both set for read-modify-write
    typedef logic [MEM_RW_W-1:0] mem_rw_t;

    typedef logic [EXC_W-1:0]    exc_type_t;

    localparam int MEM_WR_BIT = 1;

    localparam exc_type_t EXC_NONE  = 4'd0;
    localparam exc_type_t EXC_LIMIT = 4'd1;   // access ends past the segment limit
    localparam exc_type_t EXC_PROT  = 4'd2;   // write to a read-only segment

    // byte count of an access, shared by the address and limit logic
    function automatic addr_t op_bytes(opsize_t opsize);
        addr_t bytes;
        bytes = addr_t'(1) << opsize;
        return bytes;
    endfunction

endpackage

// File: design/rrag_agen.sv
module rrag_agen (
    input  rrag_pkg::addr_t   base,
    input  rrag_pkg::addr_t   index,
    input  rrag_pkg::scale_t  scale,
    input  rrag_pkg::addr_t   disp,
    input  rrag_pkg::addr_t   seg_base,
    input  rrag_pkg::opsize_t opsize,
    output rrag_pkg::addr_t   offset,
    output rrag_pkg::addr_t   lin_addr,
    output rrag_pkg::addr_t   lin_addr_end
);
    import rrag_pkg::*;

    addr_t scaled_index;
    addr_t base_disp;
    addr_t size;

    // index * 1, 2, 4 or 8
    assign scaled_index = index << scale;

    // base and displacement first, the index shift is the slower leg
    assign base_disp = base + disp;

    // effective address, all sums wrap modulo 2^32 like the real adder
    assign offset = base_disp + scaled_index;

    assign lin_addr = seg_base + offset;

    assign size = op_bytes(opsize);

    // last byte touched, the memory stage compares it with lin_addr
    // to spot accesses that straddle a cache line or a page
    assign lin_addr_end = lin_addr + size - addr_t'(1);

endmodule

// File: design/rrag_seg_check.sv
module rrag_seg_check (
    input  logic                valid,
    input  rrag_pkg::addr_t     offset,
    input  rrag_pkg::opsize_t   opsize,
    input  rrag_pkg::mem_rw_t   mem_rw,
    input  rrag_pkg::addr_t     seg_limit,
    input  logic                seg_writable,
    output logic                exc,
    output rrag_pkg::exc_type_t exc_type
);
    import rrag_pkg::*;

    logic [ADDR_W:0] end_offset;   // one extra bit so a wrap past 2^32 is visible
    logic            limit_fault;
    logic            prot_fault;

    assign end_offset = {1'b0, offset} + {1'b0, op_bytes(opsize)} - (ADDR_W+1)'(1);

    // the limit is inclusive, an access ending exactly on it is legal
    assign limit_fault = end_offset > {1'b0, seg_limit};

    assign prot_fault = mem_rw[MEM_WR_BIT] && !seg_writable;

    // limit check wins over protection
    always_comb begin
        exc      = 1'b0;
        exc_type = EXC_NONE;
        if (valid) begin
            if (limit_fault) begin
                exc      = 1'b1;
                exc_type = EXC_LIMIT;
            end else if (prot_fault) begin
                exc      = 1'b1;
                exc_type = EXC_PROT;
            end
        end
    end

endmodule

// File: design/rrag_mem_latch.sv
module rrag_mem_latch (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall,
    input  logic                flush,

    input  logic                valid_in,
    input  rrag_pkg::opsize_t   opsize_in,
    input  rrag_pkg::addr_t     mem_addr_in,
    input  rrag_pkg::addr_t     mem_addr_end_in,
    input  rrag_pkg::mem_rw_t   mem_rw_in,
    input  rrag_pkg::eip_t      eip_in,
    input  logic                exc_in,
    input  rrag_pkg::exc_type_t exc_type_in,

    output logic                valid_out,
    output rrag_pkg::opsize_t   opsize_out,
    output rrag_pkg::addr_t     mem_addr_out,
    output rrag_pkg::addr_t     mem_addr_end_out,
    output rrag_pkg::mem_rw_t   mem_rw_out,
    output rrag_pkg::eip_t      eip_out,
    output logic                exc_out,
    output rrag_pkg::exc_type_t exc_type_out
);
    import rrag_pkg::*;

    mem_rw_t mem_rw_d;
    logic    load;

    // a faulting instruction must not start a memory access
    assign mem_rw_d = exc_in ? '0 : mem_rw_in;

    // flush overrides stall so a killed slot never lingers
    assign load = !stall || flush;

    // control fields, these are the ones a flush kills
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out  <= 1'b0;
            exc_out    <= 1'b0;
            mem_rw_out <= '0;
        end else if (flush) begin
            valid_out  <= 1'b0;
            exc_out    <= 1'b0;
            mem_rw_out <= '0;
        end else if (load) begin
            valid_out  <= valid_in;
            exc_out    <= exc_in;
            mem_rw_out <= mem_rw_d;
        end
    end

    // payload follows the same load enable, its value means nothing once valid is low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opsize_out       <= '0;
            mem_addr_out     <= '0;
            mem_addr_end_out <= '0;
            eip_out          <= '0;
            exc_type_out     <= EXC_NONE;
        end else if (load) begin
            opsize_out       <= opsize_in;
            mem_addr_out     <= mem_addr_in;
            mem_addr_end_out <= mem_addr_end_in;
            eip_out          <= eip_in;
            exc_type_out     <= exc_type_in;
        end
    end

endmodule

// File: design/rrag_mem_top.sv
module rrag_mem_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall,
    input  logic                flush,

    input  logic                valid_in,
    input  rrag_pkg::opsize_t   opsize_in,
    input  rrag_pkg::addr_t     base_in,
    input  rrag_pkg::addr_t     index_in,
    input  rrag_pkg::scale_t    scale_in,
    input  rrag_pkg::addr_t     disp_in,
    input  rrag_pkg::addr_t     seg_base_in,
    input  rrag_pkg::addr_t     seg_limit_in,
    input  logic                seg_writable_in,
    input  rrag_pkg::mem_rw_t   mem_rw_in,
    input  rrag_pkg::eip_t      eip_in,

    output logic                valid_out,
    output rrag_pkg::opsize_t   opsize_out,
    output rrag_pkg::addr_t     mem_addr_out,
    output rrag_pkg::addr_t     mem_addr_end_out,
    output rrag_pkg::mem_rw_t   mem_rw_out,
    output rrag_pkg::eip_t      eip_out,
    output logic                exc_out,
    output rrag_pkg::exc_type_t exc_type_out
);
    import rrag_pkg::*;

    addr_t     offset;
    addr_t     lin_addr;
    addr_t     lin_addr_end;
    logic      exc;
    exc_type_t exc_type;

    rrag_agen u_agen (
        .base         (base_in),
        .index        (index_in),
        .scale        (scale_in),
        .disp         (disp_in),
        .seg_base     (seg_base_in),
        .opsize       (opsize_in),
        .offset       (offset),
        .lin_addr     (lin_addr),
        .lin_addr_end (lin_addr_end)
    );

    // the limit is checked on the segment offset, not the linear address
    rrag_seg_check u_seg_check (
        .valid        (valid_in),
        .offset       (offset),
        .opsize       (opsize_in),
        .mem_rw       (mem_rw_in),
        .seg_limit    (seg_limit_in),
        .seg_writable (seg_writable_in),
        .exc          (exc),
        .exc_type     (exc_type)
    );

    rrag_mem_latch u_latch (
        .clk              (clk),
        .arst_n           (arst_n),
        .stall            (stall),
        .flush            (flush),
        .valid_in         (valid_in),
        .opsize_in        (opsize_in),
        .mem_addr_in      (lin_addr),
        .mem_addr_end_in  (lin_addr_end),
        .mem_rw_in        (mem_rw_in),
        .eip_in           (eip_in),
        .exc_in           (exc),
        .exc_type_in      (exc_type),
        .valid_out        (valid_out),
        .opsize_out       (opsize_out),
        .mem_addr_out     (mem_addr_out),
        .mem_addr_end_out (mem_addr_end_out),
        .mem_rw_out       (mem_rw_out),
        .eip_out          (eip_out),
        .exc_out          (exc_out),
        .exc_type_out     (exc_type_out)
    );

endmodule

// File: tests/rrag_mem_assert.sv
module rrag_mem_assert (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall,
    input  logic                flush,
    input  logic                valid_out,
    input  rrag_pkg::opsize_t   opsize_out,
    input  rrag_pkg::addr_t     mem_addr_out,
    input  rrag_pkg::addr_t     mem_addr_end_out,
    input  rrag_pkg::mem_rw_t   mem_rw_out,
    input  rrag_pkg::eip_t      eip_out,
    input  logic                exc_out,
    input  rrag_pkg::exc_type_t exc_type_out
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // the first edge after reset release still sees the reset value
    a_reset_valid: assert property (@(posedge clk) $rose(arst_n) |-> !valid_out)
        else begin
            fail_count++;
            $error("valid_out high in the first cycle after reset release");
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        stall && !flush |=> $stable(valid_out) && $stable(opsize_out)
            && $stable(mem_addr_out) && $stable(mem_addr_end_out)
            && $stable(mem_rw_out) && $stable(eip_out)
            && $stable(exc_out) && $stable(exc_type_out))
        else begin
            fail_count++;
            $error("stage outputs changed during a stall");
        end

    // a faulting instruction never starts a memory access
    a_exc_no_access: assert property (@(posedge clk) disable iff (!arst_n)
        exc_out |-> mem_rw_out == '0)
        else begin
            fail_count++;
            $error("mem_rw_out nonzero while exc_out is set");
        end

endmodule

bind rrag_mem_latch rrag_mem_assert u_assert (
    .clk              (clk),
    .arst_n           (arst_n),
    .stall            (stall),
    .flush            (flush),
    .valid_out        (valid_out),
    .opsize_out       (opsize_out),
    .mem_addr_out     (mem_addr_out),
    .mem_addr_end_out (mem_addr_end_out),
    .mem_rw_out       (mem_rw_out),
    .eip_out          (eip_out),
    .exc_out          (exc_out),
    .exc_type_out     (exc_type_out)
);

// File: tests/rrag_mem_tb.sv
module rrag_mem_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rrag_pkg::*;

    localparam int TIMEOUT_CYCLES = 5000;

    // one expected stage word, ctrl_only marks a flushed slot whose payload is don't care
    typedef struct packed {
        logic      valid;
        opsize_t   opsize;
        addr_t     addr;
        addr_t     addr_end;
        mem_rw_t   mem_rw;
        eip_t      eip;
        logic      exc;
        exc_type_t exc_type;
        logic      ctrl_only;
    } word_t;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      stall;
    logic      flush;
    logic      valid_in;
    opsize_t   opsize_in;
    addr_t     base_in;
    addr_t     index_in;
    scale_t    scale_in;
    addr_t     disp_in;
    addr_t     seg_base_in;
    addr_t     seg_limit_in;
    logic      seg_writable_in;
    mem_rw_t   mem_rw_in;
    eip_t      eip_in;

    logic      valid_out;
    opsize_t   opsize_out;
    addr_t     mem_addr_out;
    addr_t     mem_addr_end_out;
    mem_rw_t   mem_rw_out;
    eip_t      eip_out;
    logic      exc_out;
    exc_type_t exc_type_out;

    word_t       exp_q[$];
    word_t       last_exp;
    logic [31:0] lfsr;
    logic        stim_done = 1'b0;

    always #4 clk = ~clk;

    rrag_mem_top u_rrag_mem_top (
        .clk              (clk),
        .arst_n           (arst_n),
        .stall            (stall),
        .flush            (flush),
        .valid_in         (valid_in),
        .opsize_in        (opsize_in),
        .base_in          (base_in),
        .index_in         (index_in),
        .scale_in         (scale_in),
        .disp_in          (disp_in),
        .seg_base_in      (seg_base_in),
        .seg_limit_in     (seg_limit_in),
        .seg_writable_in  (seg_writable_in),
        .mem_rw_in        (mem_rw_in),
        .eip_in           (eip_in),
        .valid_out        (valid_out),
        .opsize_out       (opsize_out),
        .mem_addr_out     (mem_addr_out),
        .mem_addr_end_out (mem_addr_end_out),
        .mem_rw_out       (mem_rw_out),
        .eip_out          (eip_out),
        .exc_out          (exc_out),
        .exc_type_out     (exc_type_out)
    );

    // x^32 + x^22 + x^2 + x + 1, one shift per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t ref_word(input logic valid, input opsize_t opsize,
                                       input addr_t base, input addr_t index,
                                       input scale_t scale, input addr_t disp,
                                       input addr_t seg_base, input addr_t seg_limit,
                                       input logic writable, input mem_rw_t mem_rw,
                                       input eip_t eip);
        word_t       w;
        logic [32:0] size;
        logic [32:0] end_off;
        addr_t       off;
        size         = 33'd1 << opsize;
        off          = base + (index << scale) + disp;
        w            = '0;
        w.valid      = valid;
        w.opsize     = opsize;
        w.eip        = eip;
        w.addr       = seg_base + off;
        w.addr_end   = w.addr + size[31:0] - 32'd1;
        end_off      = {1'b0, off} + size - 33'd1;   // no wrap, so a carry out is a fault
        w.exc_type   = EXC_NONE;
        if (valid && end_off > {1'b0, seg_limit}) begin
            w.exc      = 1'b1;
            w.exc_type = EXC_LIMIT;
        end else if (valid && mem_rw[1] && !writable) begin
            w.exc      = 1'b1;
            w.exc_type = EXC_PROT;
        end
        w.mem_rw = w.exc ? 2'b00 : mem_rw;
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("Error: %s expected %h actual %h", name, exp_v, act_v);
            $display("Finished with errors");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic compare_word(input word_t w);
        check_value("valid_out", 32'(w.valid), 32'(valid_out));
        check_value("exc_out", 32'(w.exc), 32'(exc_out));
        check_value("mem_rw_out", 32'(w.mem_rw), 32'(mem_rw_out));
        if (!w.ctrl_only) begin
            check_value("opsize_out", 32'(w.opsize), 32'(opsize_out));
            check_value("mem_addr_out", w.addr, mem_addr_out);
            check_value("mem_addr_end_out", w.addr_end, mem_addr_end_out);
            check_value("eip_out", w.eip, eip_out);
            check_value("exc_type_out", 32'(w.exc_type), 32'(exc_type_out));
        end
    endtask

    task automatic check_assertions();
        if (u_rrag_mem_top.u_latch.u_assert.fail_count != 0) begin
            $display("bound assertions failed %0d times",
                     u_rrag_mem_top.u_latch.u_assert.fail_count);
            $display("Finished with errors");
            $fatal(1, "assertion failures");
        end
    endtask

    task automatic set_op(input logic valid, input opsize_t opsize, input addr_t base,
                          input addr_t index, input scale_t scale, input addr_t disp,
                          input addr_t seg_base, input addr_t seg_limit,
                          input logic writable, input mem_rw_t mem_rw);
        valid_in        = valid;
        opsize_in       = opsize;
        base_in         = base;
        index_in        = index;
        scale_in        = scale;
        disp_in         = disp;
        seg_base_in     = seg_base;
        seg_limit_in    = seg_limit;
        seg_writable_in = writable;
        mem_rw_in       = mem_rw;
        eip_in          = rand_bits(32);
    endtask

    // full 4 GiB writable segment, only a carry past 2^32 can fault
    task automatic random_op();
        valid_in        = 1'b1;
        opsize_in       = opsize_t'(rand_bits(2));
        base_in         = rand_bits(32);
        index_in        = rand_bits(32);
        scale_in        = scale_t'(rand_bits(2));
        disp_in         = rand_bits(32);
        seg_base_in     = rand_bits(32);
        seg_limit_in    = 32'hFFFF_FFFF;
        seg_writable_in = 1'b1;
        mem_rw_in       = mem_rw_t'(rand_bits(2));
        eip_in          = rand_bits(32);
    endtask

    // queue what the outputs must show after the coming rising edge
    task automatic run_cycle(input logic stall_v, input logic flush_v);
        word_t w;
        stall = stall_v;
        flush = flush_v;
        w = ref_word(valid_in, opsize_in, base_in, index_in, scale_in, disp_in,
                     seg_base_in, seg_limit_in, seg_writable_in, mem_rw_in, eip_in);
        if (flush_v) begin
            w.valid     = 1'b0;
            w.exc       = 1'b0;
            w.mem_rw    = 2'b00;
            w.ctrl_only = 1'b1;
            last_exp    = w;
        end else if (stall_v) begin
            w = last_exp;   // dropped input, the latch keeps the old word
        end else begin
            last_exp = w;
        end
        exp_q.push_back(w);
        @(negedge clk);
    endtask

    initial begin : stimulus
        addr_t size;
        addr_t limit;
        addr_t disp;
        int    len;
        lfsr     = 32'd31;
        last_exp = '0;
        arst_n   = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
        set_op(1'b0, 2'd0, '0, '0, 2'd0, '0, '0, '0, 1'b0, 2'b00);
        eip_in   = '0;
        @(negedge clk);
        exp_q.push_back(last_exp);   // reset state seen at the second edge
        @(negedge clk);
        arst_n = 1'b1;

        // stalled right after release, valid_out must still read the reset value
        random_op();
        run_cycle(1'b1, 1'b0);

        repeat (60) begin
            random_op();
            run_cycle(1'b0, 1'b0);
        end

        for (int s = 0; s < 4; s++) begin
            repeat (4) begin
                random_op();
                opsize_in = opsize_t'(s);
                run_cycle(1'b0, 1'b0);
            end
        end

        // last byte exactly on the limit passes, one byte further faults
        for (int s = 0; s < 4; s++) begin
            size  = 32'd1 << s;
            limit = rand_bits(16) + 32'h0000_1000;
            disp  = rand_bits(8);
            set_op(1'b1, opsize_t'(s), limit - size + 32'd1 - disp, 32'd0, 2'd0, disp,
                   rand_bits(32), limit, 1'b1, 2'b11);
            run_cycle(1'b0, 1'b0);
            base_in = base_in + 32'd1;
            run_cycle(1'b0, 1'b0);
        end

        // end offset carries past 2^32 even with a 4 GiB limit
        set_op(1'b1, 2'd2, 32'hFFFF_FFFE, 32'd0, 2'd0, 32'd0, 32'h0000_1000,
               32'hFFFF_FFFF, 1'b1, 2'b01);
        run_cycle(1'b0, 1'b0);
        // here the offset itself wraps to a low address and stays legal
        set_op(1'b1, 2'd3, 32'hFFFF_FFF0, 32'd4, 2'd3, 32'd0, 32'hFFFF_0000,
               32'hFFFF_FFFF, 1'b1, 2'b10);
        run_cycle(1'b0, 1'b0);

        // read-only segment
        limit = 32'h0000_FFFF;
        set_op(1'b1, 2'd2, 32'h100, 32'h10, 2'd2, 32'h4, rand_bits(32), limit, 1'b0, 2'b10);
        run_cycle(1'b0, 1'b0);
        mem_rw_in = 2'b11;
        run_cycle(1'b0, 1'b0);
        mem_rw_in = 2'b01;
        run_cycle(1'b0, 1'b0);
        mem_rw_in = 2'b00;
        run_cycle(1'b0, 1'b0);
        base_in   = 32'h0001_0000;   // beyond the limit, the limit fault wins
        mem_rw_in = 2'b10;
        run_cycle(1'b0, 1'b0);
        valid_in  = 1'b0;            // a bubble never faults
        run_cycle(1'b0, 1'b0);
        set_op(1'b1, 2'd1, 32'h200, 32'd0, 2'd0, 32'd0, rand_bits(32), limit, 1'b1, 2'b10);
        run_cycle(1'b0, 1'b0);

        repeat (20) begin
            random_op();
            run_cycle(1'b0, 1'b0);
            len = int'(rand_bits(2)) + 1;
            repeat (len) begin
                random_op();
                run_cycle(1'b1, 1'b0);
            end
        end

        random_op();
        run_cycle(1'b0, 1'b0);
        random_op();
        run_cycle(1'b0, 1'b1);
        random_op();
        run_cycle(1'b1, 1'b0);
        random_op();
        run_cycle(1'b0, 1'b0);
        random_op();
        run_cycle(1'b1, 1'b1);   // flush beats stall
        set_op(1'b1, 2'd2, 32'hFFFF_FFFE, 32'd0, 2'd0, 32'd0, 32'd0, 32'hFFFF_FFFF,
               1'b1, 2'b11);
        run_cycle(1'b0, 1'b1);
        random_op();
        run_cycle(1'b0, 1'b0);

        valid_in = 1'b0;
        repeat (3) run_cycle(1'b0, 1'b0);
        stim_done = 1'b1;
    end

    // outputs settle after the rising edge, sample them shortly after it
    initial begin : compare_proc
        word_t w;
        int    cycles;
        cycles = 0;
        while (!(stim_done && exp_q.size() == 0)) begin
            @(posedge clk);
            #2;
            if (exp_q.size() > 0) begin
                w = exp_q.pop_front();
                compare_word(w);
            end
            check_assertions();
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("timeout: the stimulus never finished or its words were never checked");
                $display("Finished with errors");
                $fatal(1, "timeout");
            end
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: tb.f
design/rrag_pkg.sv
design/rrag_agen.sv
design/rrag_seg_check.sv
design/rrag_mem_latch.sv
design/rrag_mem_top.sv
tests/rrag_mem_assert.sv
tests/rrag_mem_tb.sv
